// File: Makefile
SIM      = verilator
TOP      = pmp_tb
FILELIST = all.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)

# The run fails unless the log holds the pass line
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: all.f
source/pmp_pkg.sv
source/pmp_reg_decode.sv
source/pmp_compare_calc.sv
source/pmp_pwm_writer.sv
source/pwm_generator.sv
source/pre_modulation_processor.sv
tests/pmp_props.sv
tests/pmp_tb.sv

// File: source/pmp_compare_calc.sv
`timescale 1ns/1ns
`default_nettype none

module pmp_compare_calc (
    input  logic                   clock,
    input  logic                   arst_n,
    input  pmp_pkg::pmp_settings_t settings,
    input  logic                   settings_update,
    output pmp_pkg::pmp_windows_t  windows,
    output logic                   windows_valid
);
    import pmp_pkg::*;

    // Adds two counts modulo the period with one conditional subtraction
    // Both operands must already be below the period for this to hold
    function automatic logic [DATA_W-1:0] mod_add(
        input logic [DATA_W-1:0] a,
        input logic [DATA_W-1:0] b,
        input logic [DATA_W-1:0] p
    );
        logic [DATA_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, p}) begin
            sum = sum - {1'b0, p};
        end
        return sum[DATA_W-1:0];
    endfunction

    // Moves both edges of a window forward by the phase shift
    function automatic pwm_window_t shift_window(
        input pwm_window_t       w,
        input logic [DATA_W-1:0] s,
        input logic [DATA_W-1:0] p
    );
        pwm_window_t shifted;
        shifted.start = mod_add(w.start, s, p);
        shifted.stop  = mod_add(w.stop, s, p);
        return shifted;
    endfunction

    logic [DATA_W-1:0] duty_max;
    logic [DATA_W-1:0] duty_clamped;
    logic [DATA_W-1:0] low_start;
    pwm_window_t       a_high;
    pwm_window_t       a_low;
    pmp_windows_t      next_windows;

    // Upper duty limit leaves room for the dead time before the wrap
    assign duty_max = settings.period - settings.dead_time;

    // Duty is held between T and P-T, the lower bound is applied last
    always_comb begin
        duty_clamped = settings.duty;
        if (duty_clamped > duty_max) begin
            duty_clamped = duty_max;
        end
        if (duty_clamped < settings.dead_time) begin
            duty_clamped = settings.dead_time;
        end
    end

    // D+T can reach P at most, so it folds back to zero there
    assign low_start = mod_add(duty_clamped, settings.dead_time, settings.period);

    // Leg A high side turns on after the dead time and off at the duty
    assign a_high.start = settings.dead_time;
    assign a_high.stop  = duty_clamped;

    // Leg A low side runs from D+T up to the carrier wrap
    assign a_low.start = low_start;
    assign a_low.stop  = '0;

    always_comb begin
        next_windows.period = settings.period;
        next_windows.a_high = a_high;
        next_windows.a_low  = a_low;
        if (settings.full_bridge) begin
            // Leg B is leg A delayed by the phase shift
            next_windows.b_high = shift_window(a_high, settings.phase, settings.period);
            next_windows.b_low  = shift_window(a_low, settings.phase, settings.period);
        end else begin
            // Empty windows keep leg B off in single-leg mode
            next_windows.b_high = '0;
            next_windows.b_low  = '0;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            windows_valid <= 1'b0;
        end else begin
            windows_valid <= settings_update;
        end
    end

    // Result is only captured when fresh settings arrive
    always_ff @(posedge clock) begin
        if (settings_update) begin
            windows <= next_windows;
        end
    end

endmodule

`default_nettype wire

// File: source/pmp_pkg.sv
`default_nettype none

package pmp_pkg;

    // Register data and every carrier count share this width
    localparam int DATA_W = 16;

    // Register addresses coming from the control bus bridge
    localparam int ADDR_W = 8;

    // Slot index carried by each generator write strobe
    localparam int SLOT_W = 4;

    // Offsets of the five registers relative to the block base address
    localparam logic [ADDR_W-1:0] REG_MODE     = 8'h00;
    localparam logic [ADDR_W-1:0] REG_PERIOD   = 8'h04;
    localparam logic [ADDR_W-1:0] REG_DUTY     = 8'h08;
    localparam logic [ADDR_W-1:0] REG_PHASE    = 8'h0C;
    localparam logic [ADDR_W-1:0] REG_DEADTIME = 8'h10;

    // Slot 0 is the period, slots 1 to 8 are the window edges in struct order
    localparam int GEN_SLOTS = 9;

    // Single-cycle register write as produced by the bus bridge
    typedef struct packed {
        logic              strobe;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] data;
    } reg_write_t;

    // Decoded converter settings, exactly as last written
    typedef struct packed {
        logic              full_bridge;
        logic [DATA_W-1:0] period;
        logic [DATA_W-1:0] duty;
        logic [DATA_W-1:0] phase;
        logic [DATA_W-1:0] dead_time;
    } pmp_settings_t;

    // Circular switching window, on for counts in [start, stop)
    typedef struct packed {
        logic [DATA_W-1:0] start;
        logic [DATA_W-1:0] stop;
    } pwm_window_t;

    // Complete generator set, nine words in slot order
    typedef struct packed {
        logic [DATA_W-1:0] period;
        pwm_window_t       a_high;
        pwm_window_t       a_low;
        pwm_window_t       b_high;
        pwm_window_t       b_low;
    } pmp_windows_t;

    // Plain write strobe into one generator slot
    typedef struct packed {
        logic              strobe;
        logic [SLOT_W-1:0] slot;
        logic [DATA_W-1:0] data;
    } gen_write_t;

endpackage

`default_nettype wire

// File: source/pmp_pwm_writer.sv
`timescale 1ns/1ns
`default_nettype none

module pmp_pwm_writer (
    input  logic                  clock,
    input  logic                  arst_n,
    input  pmp_pkg::pmp_windows_t windows,
    input  logic                  windows_valid,
    output pmp_pkg::gen_write_t   gen_wr
);
    import pmp_pkg::*;

    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(GEN_SLOTS - 1);

    // Copy of the set being sent, so the execute stage may move on
    pmp_windows_t      latched;
    logic [SLOT_W-1:0] slot;
    logic              busy;

    always_ff @(posedge clock) begin
        if (windows_valid) begin
            latched <= windows;
        end
    end

    // A new set always restarts the burst at slot 0
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            slot <= '0;
        end else if (windows_valid) begin
            busy <= 1'b1;
            slot <= '0;
        end else if (busy) begin
            if (slot == LAST_SLOT) begin
                busy <= 1'b0;
                slot <= '0;
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // One word per cycle, selected by the current slot
    always_comb begin
        gen_wr.strobe = busy;
        gen_wr.slot   = slot;
        case (slot)
            4'd0:    gen_wr.data = latched.period;
            4'd1:    gen_wr.data = latched.a_high.start;
            4'd2:    gen_wr.data = latched.a_high.stop;
            4'd3:    gen_wr.data = latched.a_low.start;
            4'd4:    gen_wr.data = latched.a_low.stop;
            4'd5:    gen_wr.data = latched.b_high.start;
            4'd6:    gen_wr.data = latched.b_high.stop;
            4'd7:    gen_wr.data = latched.b_low.start;
            4'd8:    gen_wr.data = latched.b_low.stop;
            default: gen_wr.data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/pmp_reg_decode.sv
`timescale 1ns/1ns
`default_nettype none

module pmp_reg_decode #(
    parameter logic [pmp_pkg::ADDR_W-1:0] BASE_ADDRESS = '0
) (
    input  logic                   clock,
    input  logic                   arst_n,
    input  pmp_pkg::reg_write_t    reg_in,
    output pmp_pkg::pmp_settings_t settings,
    output logic                   settings_update
);
    import pmp_pkg::*;

    // Absolute addresses of the register map
    localparam logic [ADDR_W-1:0] ADDR_MODE     = BASE_ADDRESS + REG_MODE;
    localparam logic [ADDR_W-1:0] ADDR_PERIOD   = BASE_ADDRESS + REG_PERIOD;
    localparam logic [ADDR_W-1:0] ADDR_DUTY     = BASE_ADDRESS + REG_DUTY;
    localparam logic [ADDR_W-1:0] ADDR_PHASE    = BASE_ADDRESS + REG_PHASE;
    localparam logic [ADDR_W-1:0] ADDR_DEADTIME = BASE_ADDRESS + REG_DEADTIME;

    // High when the incoming strobe hits one of the five registers
    logic write_hit;

    always_comb begin
        write_hit = 1'b0;
        if (reg_in.strobe) begin
            case (reg_in.address)
                ADDR_MODE,
                ADDR_PERIOD,
                ADDR_DUTY,
                ADDR_PHASE,
                ADDR_DEADTIME: write_hit = 1'b1;
                default:       write_hit = 1'b0;
            endcase
        end
    end

    // Register file, each accepted write loads exactly one field
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            settings <= '0;
        end else if (reg_in.strobe) begin
            case (reg_in.address)
                // Only bit 0 of the mode register is meaningful
                ADDR_MODE: begin
                    settings.full_bridge <= reg_in.data[0];
                end
                ADDR_PERIOD: begin
                    settings.period <= reg_in.data;
                end
                ADDR_DUTY: begin
                    settings.duty <= reg_in.data;
                end
                ADDR_PHASE: begin
                    settings.phase <= reg_in.data;
                end
                ADDR_DEADTIME: begin
                    settings.dead_time <= reg_in.data;
                end
                default: begin
                    // Writes outside the map leave the settings untouched
                    settings <= settings;
                end
            endcase
        end
    end

    // One-cycle pulse that lines up with the newly loaded settings
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            settings_update <= 1'b0;
        end else begin
            settings_update <= write_hit;
        end
    end

endmodule

`default_nettype wire

// File: source/pre_modulation_processor.sv
`timescale 1ns/1ns
`default_nettype none

module pre_modulation_processor #(
    parameter logic [pmp_pkg::ADDR_W-1:0] BASE_ADDRESS = '0
) (
    input  logic                clock,
    input  logic                arst_n,
    input  pmp_pkg::reg_write_t reg_in,
    output logic                pwm_a_high,
    output logic                pwm_a_low,
    output logic                pwm_b_high,
    output logic                pwm_b_low,
    output logic                period_start
);
    import pmp_pkg::*;

    pmp_settings_t settings;
    logic          settings_update;
    pmp_windows_t  windows;
    logic          windows_valid;
    gen_write_t    gen_wr;

    // Decode stage, the only block that knows the register map
    pmp_reg_decode #(
        .BASE_ADDRESS(BASE_ADDRESS)
    ) u_decode (
        .clock          (clock),
        .arst_n         (arst_n),
        .reg_in         (reg_in),
        .settings       (settings),
        .settings_update(settings_update)
    );

    // Execute stage turns settings into the four switching windows
    pmp_compare_calc u_calc (
        .clock          (clock),
        .arst_n         (arst_n),
        .settings       (settings),
        .settings_update(settings_update),
        .windows        (windows),
        .windows_valid  (windows_valid)
    );

    // Result stage streams the set into the generator slots
    pmp_pwm_writer u_writer (
        .clock        (clock),
        .arst_n       (arst_n),
        .windows      (windows),
        .windows_valid(windows_valid),
        .gen_wr       (gen_wr)
    );

    pwm_generator u_generator (
        .clock       (clock),
        .arst_n      (arst_n),
        .gen_wr      (gen_wr),
        .pwm_a_high  (pwm_a_high),
        .pwm_a_low   (pwm_a_low),
        .pwm_b_high  (pwm_b_high),
        .pwm_b_low   (pwm_b_low),
        .period_start(period_start)
    );

endmodule

`default_nettype wire

// File: source/pwm_generator.sv
`timescale 1ns/1ns
`default_nettype none

module pwm_generator (
    input  logic                clock,
    input  logic                arst_n,
    input  pmp_pkg::gen_write_t gen_wr,
    output logic                pwm_a_high,
    output logic                pwm_a_low,
    output logic                pwm_b_high,
    output logic                pwm_b_low,
    output logic                period_start
);
    import pmp_pkg::*;

    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(GEN_SLOTS - 1);

    // Window rule shared by all four outputs
    function automatic logic in_window(
        input logic [DATA_W-1:0] c,
        input pwm_window_t       w
    );
        logic on;
        if (w.start < w.stop) begin
            on = (c >= w.start) && (c < w.stop);
        end else if (w.start > w.stop) begin
            // Window straddles the carrier wrap
            on = (c >= w.start) || (c < w.stop);
        end else begin
            on = 1'b0;
        end
        return on;
    endfunction

    pmp_windows_t      staging_set;
    pmp_windows_t      active_set;
    logic              pending;
    logic [DATA_W-1:0] counter;
    logic              wrap;

    // An idle counter counts as wrapping every cycle so a new set loads at once
    assign wrap = (active_set.period == '0) || (counter == active_set.period - 1'b1);

    // Staging words are overwritten slot by slot during a burst
    always_ff @(posedge clock) begin
        if (gen_wr.strobe) begin
            case (gen_wr.slot)
                4'd0:    staging_set.period       <= gen_wr.data;
                4'd1:    staging_set.a_high.start <= gen_wr.data;
                4'd2:    staging_set.a_high.stop  <= gen_wr.data;
                4'd3:    staging_set.a_low.start  <= gen_wr.data;
                4'd4:    staging_set.a_low.stop   <= gen_wr.data;
                4'd5:    staging_set.b_high.start <= gen_wr.data;
                4'd6:    staging_set.b_high.stop  <= gen_wr.data;
                4'd7:    staging_set.b_low.start  <= gen_wr.data;
                4'd8:    staging_set.b_low.stop   <= gen_wr.data;
                default: staging_set <= staging_set;
            endcase
        end
    end

    // The active set only changes at a wrap, never mid-period
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            active_set <= '0;
            pending    <= 1'b0;
            counter    <= '0;
        end else begin
            if (pending && wrap) begin
                active_set <= staging_set;
                pending    <= 1'b0;
            end
            // A burst in progress invalidates the pending set until slot 8 lands
            if (gen_wr.strobe) begin
                pending <= (gen_wr.slot == LAST_SLOT);
            end
            if (wrap) begin
                counter <= '0;
            end else begin
                counter <= counter + 1'b1;
            end
        end
    end

    // Gate outputs and period_start trail the counter by one cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pwm_a_high   <= 1'b0;
            pwm_a_low    <= 1'b0;
            pwm_b_high   <= 1'b0;
            pwm_b_low    <= 1'b0;
            period_start <= 1'b0;
        end else begin
            pwm_a_high   <= in_window(counter, active_set.a_high);
            pwm_a_low    <= in_window(counter, active_set.a_low);
            pwm_b_high   <= in_window(counter, active_set.b_high);
            pwm_b_low    <= in_window(counter, active_set.b_low);
            period_start <= (active_set.period != '0) && (counter == '0);
        end
    end

endmodule

`default_nettype wire

// File: tests/pmp_props.sv
`timescale 1ns/1ns
`default_nettype none

module pmp_props (
    input logic                        clock,
    input logic                        arst_n,
    input pmp_pkg::gen_write_t         gen_wr,
    input logic                        pwm_a_high,
    input logic                        pwm_a_low,
    input logic                        pwm_b_high,
    input logic                        pwm_b_low,
    input logic                        period_start,
    input logic [pmp_pkg::DATA_W-1:0]  active_period
);
    import pmp_pkg::*;

    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(GEN_SLOTS - 1);

    // Set once the generator has taken the last slot of a complete set
    logic set_delivered;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            set_delivered <= 1'b0;
        end else if (gen_wr.strobe && (gen_wr.slot == LAST_SLOT)) begin
            set_delivered <= 1'b1;
        end
    end

    // High and low side of one leg must never conduct together
    assert property (@(posedge clock) disable iff (!arst_n)
        !(pwm_a_high && pwm_a_low) && !(pwm_b_high && pwm_b_low))
    else $error("high and low side of one leg are on together");

    // Within a burst each strobe carries the next slot, and a restart goes back to 0
    assert property (@(posedge clock) disable iff (!arst_n)
        (gen_wr.strobe && $past(gen_wr.strobe) && gen_wr.slot != '0)
        |-> (gen_wr.slot == $past(gen_wr.slot) + 4'd1))
    else $error("generator slot index skipped within a burst");

    // The counter idles at a zero period until a whole set has reached the generator
    // A period start also needs a nonzero active period in the cycle it is seen
    assert property (@(posedge clock) disable iff (!arst_n)
        period_start |-> (set_delivered && (active_period != '0)))
    else $error("period_start pulsed before a full set or with a zero active period");

endmodule

// The writer burst is observed where it enters the generator
bind pwm_generator pmp_props u_props (
    .clock        (clock),
    .arst_n       (arst_n),
    .gen_wr       (gen_wr),
    .pwm_a_high   (pwm_a_high),
    .pwm_a_low    (pwm_a_low),
    .pwm_b_high   (pwm_b_high),
    .pwm_b_low    (pwm_b_low),
    .period_start (period_start),
    .active_period(active_set.period)
);

`default_nettype wire

// File: tests/pmp_tb.sv
`timescale 1ns/1ns
`default_nettype none

module pmp_tb;
    import pmp_pkg::*;

    localparam logic [ADDR_W-1:0] BASE_ADDRESS = 8'h00;

    // Four configurations at period 100, one at 80 and five random ones of up to 200
    // Each takes about four periods, and the idle check adds a few dozen cycles
    localparam int TIMEOUT_CYCLES = 6000;

    logic         clock;
    logic         arst_n;
    reg_write_t   reg_in;
    logic         pwm_a_high;
    logic         pwm_a_low;
    logic         pwm_b_high;
    logic         pwm_b_low;
    logic         period_start;

    // Register values as last written through the register port
    int           model_mode;
    int           model_period;
    int           model_duty;
    int           model_phase;
    int           model_dead;

    // Handshake between the stimulus and the comparing process
    pmp_windows_t exp_set;
    logic         check_go;
    logic         check_done;

    int           test_errors;
    int           pass_count;
    int           fail_count;
    int           cycle_count;
    integer       seed;

    pre_modulation_processor #(
        .BASE_ADDRESS(BASE_ADDRESS)
    ) u_dut (
        .clock       (clock),
        .arst_n      (arst_n),
        .reg_in      (reg_in),
        .pwm_a_high  (pwm_a_high),
        .pwm_a_low   (pwm_a_low),
        .pwm_b_high  (pwm_b_high),
        .pwm_b_low   (pwm_b_low),
        .period_start(period_start)
    );

    always #50 clock = ~clock;

    // Expected windows worked out directly from the register values
    function automatic pmp_windows_t reference_windows(
        input int mode,
        input int p,
        input int d,
        input int s,
        input int t
    );
        pmp_windows_t w;
        int dc;
        dc = d;
        if (dc > p - t) dc = p - t;
        if (dc < t) dc = t;
        w.period       = DATA_W'(p);
        w.a_high.start = DATA_W'(t);
        w.a_high.stop  = DATA_W'(dc);
        w.a_low.start  = DATA_W'((dc + t) % p);
        w.a_low.stop   = '0;
        if (mode % 2 == 1) begin
            // Leg B is leg A moved later by the phase and wrapped into the period
            w.b_high.start = DATA_W'((t + s) % p);
            w.b_high.stop  = DATA_W'((dc + s) % p);
            w.b_low.start  = DATA_W'((((dc + t) % p) + s) % p);
            w.b_low.stop   = DATA_W'(s % p);
        end else begin
            w.b_high = '0;
            w.b_low  = '0;
        end
        return w;
    endfunction

    // Circular window test at one carrier count
    function automatic logic window_on(input int c, input pwm_window_t w);
        int a;
        int b;
        a = w.start;
        b = w.stop;
        if (a < b) return (c >= a) && (c < b);
        if (a > b) return (c >= a) || (c < b);
        return 1'b0;
    endfunction

    task automatic compare_gate(input string name, input int count, input logic got,
                                input logic expected);
        if (got !== expected) begin
            $display("FAIL %0t ns: %s at count %0d is %b, expected %b",
                     $time, name, count, got, expected);
            test_errors++;
        end
    endtask

    // Waits until the new set is surely active and then checks one whole period
    initial begin : compare_process
        int seen;
        int count;
        int period;
        check_done = 1'b0;
        forever begin
            wait (check_go);
            period = exp_set.period;
            seen = 0;
            while (seen < 3) begin
                @(negedge clock);
                if (period_start) seen++;
            end
            // The pulse itself lines up with the outputs for count 0
            for (count = 0; count < period; count++) begin
                if (count > 0) @(negedge clock);
                compare_gate("pwm_a_high", count, pwm_a_high, window_on(count, exp_set.a_high));
                compare_gate("pwm_a_low", count, pwm_a_low, window_on(count, exp_set.a_low));
                compare_gate("pwm_b_high", count, pwm_b_high, window_on(count, exp_set.b_high));
                compare_gate("pwm_b_low", count, pwm_b_low, window_on(count, exp_set.b_low));
                compare_gate("period_start", count, period_start, count == 0);
            end
            check_done = 1'b1;
            wait (!check_go);
            check_done = 1'b0;
        end
    end

    // Drives one write from a falling edge and holds the strobe for exactly one cycle
    task automatic write_register(input logic [ADDR_W-1:0] address, input int value);
        reg_in.strobe  = 1'b1;
        reg_in.address = address;
        reg_in.data    = DATA_W'(value);
        if (address == BASE_ADDRESS + REG_MODE) model_mode = value % 2;
        else if (address == BASE_ADDRESS + REG_PERIOD) model_period = value;
        else if (address == BASE_ADDRESS + REG_DUTY) model_duty = value;
        else if (address == BASE_ADDRESS + REG_PHASE) model_phase = value;
        else if (address == BASE_ADDRESS + REG_DEADTIME) model_dead = value;
        @(negedge clock);
        reg_in.strobe = 1'b0;
    endtask

    task automatic configure(input int mode, input int p, input int d, input int s, input int t);
        write_register(BASE_ADDRESS + REG_PERIOD, p);
        write_register(BASE_ADDRESS + REG_DUTY, d);
        write_register(BASE_ADDRESS + REG_PHASE, s);
        write_register(BASE_ADDRESS + REG_DEADTIME, t);
        write_register(BASE_ADDRESS + REG_MODE, mode);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("[%0t ns] %s: ok", $time, name);
        end else begin
            fail_count++;
            $display("[%0t ns] %s: %0d mismatches", $time, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic run_check(input string name, input pmp_windows_t expected);
        exp_set  = expected;
        check_go = 1'b1;
        wait (check_done);
        check_go = 1'b0;
        wait (!check_done);
        finish_test(name);
    endtask

    function automatic pmp_windows_t model_windows();
        return reference_windows(model_mode, model_period, model_duty, model_phase, model_dead);
    endfunction

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out: not finished after %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin : stimulus
        int p;
        int d;
        int s;
        int t;
        int m;
        clock        = 1'b0;
        arst_n       = 1'b0;
        reg_in       = '0;
        check_go     = 1'b0;
        test_errors  = 0;
        pass_count   = 0;
        fail_count   = 0;
        cycle_count  = 0;
        seed         = 62290;
        model_mode   = 0;
        model_period = 0;
        model_duty   = 0;
        model_phase  = 0;
        model_dead   = 0;
        repeat (2) @(negedge clock);
        arst_n = 1'b1;

        // Nothing written yet, so the counter idles and every output stays low
        repeat (50) begin
            @(negedge clock);
            if (pwm_a_high || pwm_a_low || pwm_b_high || pwm_b_low || period_start) begin
                $display("FAIL %0t ns: output high after reset without any write", $time);
                test_errors++;
            end
        end
        finish_test("reset idle");

        configure(0, 100, 50, 20, 4);
        run_check("single leg", model_windows());

        configure(1, 100, 50, 20, 4);
        run_check("full bridge", model_windows());

        // Out of range duties must match the limits written exactly
        configure(1, 100, 120, 20, 4);
        run_check("duty above limit", reference_windows(1, 100, 96, 20, 4));
        configure(1, 100, 1, 20, 4);
        run_check("duty below limit", reference_windows(1, 100, 4, 20, 4));

        // Stray addresses and writes spaced closer than one burst
        write_register(8'h14, 16'h1234);
        write_register(BASE_ADDRESS + REG_PERIOD, 80);
        repeat (2) @(negedge clock);
        write_register(8'h40, 7);
        write_register(BASE_ADDRESS + REG_DUTY, 30);
        repeat (3) @(negedge clock);
        write_register(BASE_ADDRESS + REG_DUTY, 35);
        write_register(BASE_ADDRESS + REG_PHASE, 10);
        write_register(BASE_ADDRESS + REG_DEADTIME, 3);
        write_register(8'h11, 50);
        write_register(8'h05, 1);
        write_register(BASE_ADDRESS + REG_MODE, 1);
        run_check("stray and quick writes", model_windows());

        for (int i = 0; i < 5; i++) begin
            p = 20 + $unsigned($random(seed)) % 181;
            t = $unsigned($random(seed)) % (p / 4);
            d = $unsigned($random(seed)) % (p + p / 2);
            s = $unsigned($random(seed)) % p;
            m = $unsigned($random(seed)) % 2;
            configure(m, p, d, s, t);
            run_check($sformatf("random %0d (P=%0d D=%0d S=%0d T=%0d mode %0d)",
                                i, p, d, s, t, m), model_windows());
        end

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
